/* hw/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// address bits, sets the number of entries
`define MEM_ADDR_W 6

// width of one data word
`define MEM_DATA_W 8

// width of the write-sequence tag kept beside each word
`define MEM_TAG_W 4

// one entry per address value
`define MEM_DEPTH (1 << `MEM_ADDR_W)

`endif

/* hw/mem_pkg.sv */
`include "mem_settings.svh"

// ------------------------------------------------------------
// shared types for the strobe memory
// ------------------------------------------------------------
package mem_pkg;

  // word address into both banks
  typedef logic [`MEM_ADDR_W-1:0] addr_t;

  // one stored data word
  typedef logic [`MEM_DATA_W-1:0] data_t;

  // write-sequence tag, zero is reserved
  typedef logic [`MEM_TAG_W-1:0] tag_t;

  // ------------------------------------------------------------
  // tag encodings
  // ------------------------------------------------------------

  // entry has not been written since reset
  localparam tag_t tag_none = '0;

  // first live tag, also the value after a wrap
  localparam tag_t tag_first = tag_t'(1);

  // last live tag before the counter wraps
  localparam tag_t tag_last = '1;

endpackage

/* hw/mem_bank.sv */
`timescale 1ns/100ps

`include "mem_settings.svh"

// ------------------------------------------------------------
// one bank of the store
// ------------------------------------------------------------
// synchronous write, registered read, write-first
// the payload type is chosen per instance
module mem_bank #(
  parameter type payload_t = mem_pkg::data_t
) (
  input  logic           mif,
  input  logic           rst_n,
  input  logic           en,
  input  logic           we,
  input  mem_pkg::addr_t addr,
  input  payload_t       wdata,
  output payload_t       rdata
);

  // storage array, one entry per address
  payload_t mem [`MEM_DEPTH];

  // ------------------------------------------------------------
  // array access
  // ------------------------------------------------------------
  // small array, so every entry clears on reset
  // rdata only moves on an enabled edge and holds otherwise
  always_ff @(posedge mif or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else if (en) begin
      if (we) begin
        // store the word
        mem[addr] <= wdata;
        // write-first, new value goes straight to the read port
        rdata <= wdata;
      end else begin
        // plain read of the addressed entry
        rdata <= mem[addr];
      end
    end
  end

endmodule

/* hw/mem_port.sv */
`timescale 1ns/100ps

// ------------------------------------------------------------
// port block of the strobe memory
// ------------------------------------------------------------
// takes one request per edge, drives both banks in parallel,
// stamps writes with a sequence tag and builds the response
// that shows up with ready one cycle later
module mem_port (
  input  logic           mif,
  input  logic           rst_n,
  input  logic           start,
  input  logic           rw,
  input  mem_pkg::addr_t addr,
  input  mem_pkg::data_t wdata,

  // shared bank controls
  output logic           bank_en,
  output logic           bank_we,
  output mem_pkg::addr_t bank_addr,

  // per bank write payloads
  output mem_pkg::data_t data_wdata,
  output mem_pkg::tag_t  tag_wdata,

  // per bank read results
  input  mem_pkg::data_t data_rdata,
  input  mem_pkg::tag_t  tag_rdata,

  // response side
  output logic           ready,
  output mem_pkg::data_t rdata,
  output mem_pkg::tag_t  rtag,
  output logic           unwritten
);

  // current write-sequence value
  mem_pkg::tag_t tag_cnt;

  // value the counter takes after the next write
  mem_pkg::tag_t tag_cnt_nxt;

  // request is a write on this edge
  logic wr_req;

  // ------------------------------------------------------------
  // request fan-out
  // ------------------------------------------------------------

  // rw only matters when start is high
  assign wr_req = start & rw;

  // both banks see the same enable, write enable and address
  assign bank_en   = start;
  assign bank_we   = wr_req;
  assign bank_addr = addr;

  // data bank stores the caller's word
  assign data_wdata = wdata;

  // tag bank stores the current sequence value
  assign tag_wdata = tag_cnt;

  // ------------------------------------------------------------
  // tag counter
  // ------------------------------------------------------------

  // counts 1 up to the top value, then back to 1
  // zero is skipped so it can mark untouched entries
  always_comb begin
    if (tag_cnt == mem_pkg::tag_last) begin
      tag_cnt_nxt = mem_pkg::tag_first;
    end else begin
      tag_cnt_nxt = tag_cnt + mem_pkg::tag_t'(1);
    end
  end

  // advance once per accepted write
  always_ff @(posedge mif or negedge rst_n) begin
    if (!rst_n) begin
      tag_cnt <= mem_pkg::tag_first;
    end else if (wr_req) begin
      tag_cnt <= tag_cnt_nxt;
    end
  end

  // ------------------------------------------------------------
  // ready pipeline
  // ------------------------------------------------------------

  // banks answer one edge after the request, and so does ready
  // a held start gives ready on every following cycle
  always_ff @(posedge mif or negedge rst_n) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= start;
    end
  end

  // ------------------------------------------------------------
  // response merge
  // ------------------------------------------------------------

  // bank outputs are already registered, so the merge is plain logic
  assign rdata = data_rdata;
  assign rtag  = tag_rdata;

  // tag zero only survives in entries never written since reset
  assign unwritten = (tag_rdata == mem_pkg::tag_none);

endmodule

/* hw/mem_top.sv */
`timescale 1ns/100ps

// ------------------------------------------------------------
// strobe memory top level
// ------------------------------------------------------------
// port block in front of a data bank and a tag bank,
// both banks are accessed in the same cycle
module mem_top (
  input  logic           mif,
  input  logic           rst_n,
  input  logic           start,
  input  logic           rw,
  input  mem_pkg::addr_t addr,
  input  mem_pkg::data_t wdata,
  output logic           ready,
  output mem_pkg::data_t rdata,
  output mem_pkg::tag_t  rtag,
  output logic           unwritten
);

  // controls shared by both banks
  logic           bank_en;
  logic           bank_we;
  mem_pkg::addr_t bank_addr;

  // write payloads
  mem_pkg::data_t data_wdata;
  mem_pkg::tag_t  tag_wdata;

  // registered bank outputs
  mem_pkg::data_t data_rdata;
  mem_pkg::tag_t  tag_rdata;

  // ------------------------------------------------------------
  // port block
  // ------------------------------------------------------------
  mem_port port_i (
    .mif        (mif),
    .rst_n      (rst_n),
    .start      (start),
    .rw         (rw),
    .addr       (addr),
    .wdata      (wdata),
    .bank_en    (bank_en),
    .bank_we    (bank_we),
    .bank_addr  (bank_addr),
    .data_wdata (data_wdata),
    .tag_wdata  (tag_wdata),
    .data_rdata (data_rdata),
    .tag_rdata  (tag_rdata),
    .ready      (ready),
    .rdata      (rdata),
    .rtag       (rtag),
    .unwritten  (unwritten)
  );

  // ------------------------------------------------------------
  // banks
  // ------------------------------------------------------------

  // data words
  mem_bank #(
    .payload_t (mem_pkg::data_t)
  ) data_bank_i (
    .mif   (mif),
    .rst_n (rst_n),
    .en    (bank_en),
    .we    (bank_we),
    .addr  (bank_addr),
    .wdata (data_wdata),
    .rdata (data_rdata)
  );

  // write-sequence tags
  mem_bank #(
    .payload_t (mem_pkg::tag_t)
  ) tag_bank_i (
    .mif   (mif),
    .rst_n (rst_n),
    .en    (bank_en),
    .we    (bank_we),
    .addr  (bank_addr),
    .wdata (tag_wdata),
    .rdata (tag_rdata)
  );

endmodule

/* verif/mem_tb_dump.svh */
`ifndef MEM_TB_DUMP_SVH
`define MEM_TB_DUMP_SVH

// ------------------------------------------------------------
// reference memory dump
// ------------------------------------------------------------
// sixteen words per row: address, hex words, then ascii
task automatic dump_ref_mem();
  string hex_part;
  string asc_part;
  mem_pkg::data_t b;
  int row;
  int col;
  $display("reference memory, %0d words", `MEM_DEPTH);
  for (row = 0; row < `MEM_DEPTH; row += 16) begin
    hex_part = "";
    asc_part = "";
    for (col = 0; col < 16; col++) begin
      b = ref_data[row + col];
      hex_part = {hex_part, $sformatf(" %h", b)};
      // control codes and high bytes print as a dot
      if (b >= 8'h20 && b <= 8'h7e) begin
        asc_part = {asc_part, $sformatf("%c", b)};
      end else begin
        asc_part = {asc_part, "."};
      end
    end
    $display("%h:%s  |%s|", mem_pkg::addr_t'(row), hex_part, asc_part);
  end
endtask

`endif

/* verif/mem_tb.sv */
`timescale 1ns/100ps

`include "mem_settings.svh"

module mem_tb;

  // expected response of one accepted request
  typedef struct packed {
    mem_pkg::data_t data;
    mem_pkg::tag_t  tag;
    logic           unw;
  } resp_t;

  // highest live tag, the counter goes back to 1 after it
  localparam mem_pkg::tag_t tag_max = '1;

  // worst case length of all tests in cycles
  // the random test idles up to 3 cycles after each request
  localparam int request_cycles = 4 + 4 + 2 + 32 + 20 + 300 * 4 + 4 + `MEM_DEPTH + 2 + 6 * 3;

  // DUT ports
  logic           mif;
  logic           rst_n;
  logic           start;
  logic           rw;
  mem_pkg::addr_t addr;
  mem_pkg::data_t wdata;
  logic           ready;
  mem_pkg::data_t rdata;
  mem_pkg::tag_t  rtag;
  logic           unwritten;

  // reference model, one data word and one tag per address
  mem_pkg::data_t ref_data [`MEM_DEPTH];
  mem_pkg::tag_t  ref_tag  [`MEM_DEPTH];
  mem_pkg::tag_t  ref_cnt;

  // responses still owed by the DUT, oldest first
  resp_t exp_q [$];

  int   seed = 34;
  int   errs = 0;
  int   checks = 0;
  int   test_no = 1;
  int   test_errs_start = 0;
  logic prev_start;

  `include "mem_tb_dump.svh"

  mem_top mem_top_i (
    .mif       (mif),
    .rst_n     (rst_n),
    .start     (start),
    .rw        (rw),
    .addr      (addr),
    .wdata     (wdata),
    .ready     (ready),
    .rdata     (rdata),
    .rtag      (rtag),
    .unwritten (unwritten)
  );

  // 100 ns period
  always #50 mif = ~mif;

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // everything zero, counter back at its first live value
  function automatic void clear_ref();
    int i;
    for (i = 0; i < `MEM_DEPTH; i++) begin
      ref_data[i] = '0;
      ref_tag[i]  = '0;
    end
    ref_cnt = mem_pkg::tag_t'(1);
  endfunction

  // a write stamps the current count, then the count moves on
  // reads and writes both return the entry as it is afterwards
  function automatic resp_t ref_access(input logic is_wr, input mem_pkg::addr_t a,
                                       input mem_pkg::data_t d);
    resp_t r;
    if (is_wr) begin
      ref_data[a] = d;
      ref_tag[a]  = ref_cnt;
      // zero never comes back as a live tag
      if (ref_cnt == tag_max) begin
        ref_cnt = mem_pkg::tag_t'(1);
      end else begin
        ref_cnt = ref_cnt + mem_pkg::tag_t'(1);
      end
    end
    r.data = ref_data[a];
    r.tag  = ref_tag[a];
    r.unw  = (ref_tag[a] == '0);
    return r;
  endfunction

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_data(input string name, input mem_pkg::data_t exp,
                            input mem_pkg::data_t act);
    checks++;
    if (act !== exp) begin
      errs++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input mem_pkg::tag_t exp,
                           input mem_pkg::tag_t act);
    checks++;
    if (act !== exp) begin
      errs++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errs++;
      $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // ready must follow start by exactly one edge
  // values sampled on the edge are the ones before it
  always @(posedge mif) begin
    resp_t exp;
    if (!rst_n) begin
      prev_start = 1'b0;
    end else begin
      if (ready !== prev_start) begin
        errs++;
        $display("t=%0t ready is %b but start one edge earlier was %b",
                 $time, ready, prev_start);
      end
      if (ready === 1'b1) begin
        if (exp_q.size() == 0) begin
          errs++;
          $display("t=%0t ready came with no request outstanding", $time);
        end else begin
          exp = exp_q.pop_front();
          check_data("rdata", exp.data, rdata);
          check_tag("rtag", exp.tag, rtag);
          check_bit("unwritten", exp.unw, unwritten);
        end
      end
      prev_start = start;
    end
  end

  // ------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------

  // one request on the next edge, the DUT takes it one edge later
  task automatic issue(input logic is_wr, input mem_pkg::addr_t a, input mem_pkg::data_t d);
    @(posedge mif);
    start <= 1'b1;
    rw    <= is_wr;
    addr  <= a;
    wdata <= d;
    exp_q.push_back(ref_access(is_wr, a, d));
  endtask

  task automatic idle();
    @(posedge mif);
    start <= 1'b0;
  endtask

  // let the last response arrive, then report the test
  task automatic end_test(input string name);
    idle();
    repeat (2) @(posedge mif);
    if (exp_q.size() != 0) begin
      $display("test %0d %s: missing ready for %0d requests", test_no, name, exp_q.size());
      errs += exp_q.size();
      exp_q.delete();
    end
    if (errs == test_errs_start) begin
      $display("test %0d %s: ok", test_no, name);
    end else begin
      $display("test %0d %s: failed, %0d errors", test_no, name, errs - test_errs_start);
    end
    test_no++;
    test_errs_start = errs;
  endtask

  // ------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------
  initial begin
    #((request_cycles + 20) * 100);
    $display("watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    int r;
    int i;
    logic [1:0] gap;
    mif   = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    rw    = 1'b0;
    addr  = '0;
    wdata = '0;
    prev_start = 1'b0;
    clear_ref();
    repeat (4) @(posedge mif);
    rst_n <= 1'b1;

    // write two words, read both back
    issue(1'b1, mem_pkg::addr_t'(5), mem_pkg::data_t'('ha5));
    issue(1'b1, mem_pkg::addr_t'(10), mem_pkg::data_t'('h3c));
    issue(1'b0, mem_pkg::addr_t'(5), '0);
    issue(1'b0, mem_pkg::addr_t'(10), '0);
    end_test("write then read");

    // untouched entries
    issue(1'b0, mem_pkg::addr_t'(62), '0);
    issue(1'b0, mem_pkg::addr_t'(63), '0);
    end_test("read unwritten");

    // start held high, every write read back on the very next edge
    for (i = 0; i < 32; i++) begin
      if (i % 2 == 0) begin
        r = $random(seed);
        issue(1'b1, mem_pkg::addr_t'(32 + i / 2), mem_pkg::data_t'(r));
      end else begin
        issue(1'b0, mem_pkg::addr_t'(32 + i / 2), '0);
      end
    end
    end_test("back to back");

    // more writes than live tags, so the counter wraps
    for (i = 0; i < 20; i++) begin
      issue(1'b1, mem_pkg::addr_t'(i), mem_pkg::data_t'(65 + i));
    end
    end_test("tag wrap");

    // random mix, gaps of 0 to 3 idle cycles
    for (i = 0; i < 300; i++) begin
      r = $random(seed);
      issue(r[0], mem_pkg::addr_t'(r >>> 1), mem_pkg::data_t'(r >>> 8));
      gap = r[31:30];
      repeat (gap) idle();
    end
    end_test("random");

    // reset in mid-run, then every address reads as unwritten
    @(posedge mif);
    rst_n <= 1'b0;
    clear_ref();
    repeat (4) @(posedge mif);
    rst_n <= 1'b1;
    for (i = 0; i < `MEM_DEPTH; i++) begin
      issue(1'b0, mem_pkg::addr_t'(i), '0);
    end
    // first write after reset gets the first live tag again
    issue(1'b1, mem_pkg::addr_t'(7), mem_pkg::data_t'('h4b));
    issue(1'b0, mem_pkg::addr_t'(7), '0);
    end_test("second reset");

    dump_ref_mem();
    $display("%0d tests, %0d checks, %0d errors", test_no - 1, checks, errs);
    if (errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+hw
+incdir+verif
hw/mem_pkg.sv
hw/mem_bank.sv
hw/mem_port.sv
hw/mem_top.sv
verif/mem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the strobe memory testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  -f flist.f \
  --top-module mem_tb \
  -o mem_sim

./obj_dir/mem_sim > sim.log
cat sim.log

# the testbench prints the failure line on any mismatch or timeout
if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
